// File: common/periph_cfg.svh
/*
 * Peripheral wrapper sizes and slot numbers
 */

`ifndef PERIPH_CFG_SVH
`define PERIPH_CFG_SVH

// Slots in each address space
`define N_SLOTS 16

// Populated byte slots, numbered from 0
`define N_BYTE_PERI 4

// User slot of the GPIO block
`define GPIO_SLOT 1

// Output pins
`define N_PINS 8

// Function select, top bit picks the byte space
`define FUNC_SEL_W 5

// Registers in each byte peripheral
`define BYTE_REGS 4

`endif

// File: common/periph_pkg.sv
/*
 * Peripheral wrapper types
 * Core request, slot selects, byte-slot write bundle and the
 * access size and GPIO register encodings
 */

`include "periph_cfg.svh"

package periph_pkg;

    // Access size, shared by the write and read fields of a request
    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10,
        ACC_NONE = 2'b11   // Idle
    } access_e;

    // Request from the core, one per cycle
    typedef struct packed {
        logic [10:0] addr;
        logic [31:0] wdata;
        access_e     write_n;
        access_e     read_n;
    } bus_req_t;

    // One-hot slot selects over both address spaces
    typedef struct packed {
        logic [`N_SLOTS-1:0] user;     // 64 byte slots, full width
        logic [`N_SLOTS-1:0] simple;   // 16 byte slots, byte wide
    } slot_sel_t;

    // Byte-slot access
    typedef struct packed {
        logic [3:0] addr;
        logic [7:0] data;
        logic       wr;
    } byte_wr_t;

    // GPIO register offsets inside its 64 byte slot
    typedef enum logic [5:0] {
        GPIO_OUT      = 6'h00,
        GPIO_IN       = 6'h04,
        FUNC_SEL_BASE = 6'h20    // Eight select words, 0x20 to 0x3c
    } gpio_reg_e;

endpackage

// File: dv/tb_periph_top.sv
/*
 * Testbench for the peripheral wrapper
 * LFSR driven bus traffic checked against a shadow register model,
 * with concurrent checks on ready timing and the output pins
 */

`timescale 1ns/1ps
`include "periph_cfg.svh"

module tb_periph_top;

    localparam int          CLK_PERIOD = 8;
    localparam logic [31:0] SEED       = 32'h2a7e;
    localparam int          FW         = `FUNC_SEL_W;
    localparam logic [3:0]  GPIO_USER  = 4'(`GPIO_SLOT);
    localparam int          N_RAND     = 24;
    localparam int          READY_WAIT = 16;
    localparam int          WR_CYC     = 2;
    localparam int          RD_CYC     = 8;    // Request, ready, hold and complete
    localparam int          T_GPIO     = WR_CYC + 3 * RD_CYC;
    localparam int          T_BYTE     = (N_RAND + `N_BYTE_PERI) * WR_CYC + 47 * RD_CYC;
    localparam int          T_FUNC     = `N_PINS * (2 * WR_CYC + RD_CYC) + 4 * (WR_CYC + RD_CYC);
    localparam int          TIMEOUT_CYCLES = 2 * (4 + T_GPIO + T_BYTE + T_FUNC);

    logic                  clk;
    logic                  rst_n;
    periph_pkg::bus_req_t  req;
    logic                  read_complete;
    logic [7:0]            ui_in;
    logic [`N_PINS-1:0]    uo_out;
    logic [31:0]           data_out;
    logic                  data_ready;

    // Shadow copy of the DUT registers
    logic [7:0]            shadow_out;
    logic [FW-1:0]         shadow_sel [`N_PINS];
    logic [7:0]            shadow_byte [`N_BYTE_PERI][`BYTE_REGS];
    logic [`N_PINS-1:0]    exp_uo;

    logic [31:0]           lfsr;
    int                    err_count;
    int                    cycle_count;
    int                    n_reads;
    int                    n_writes;

    periph_top u_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .i_req            (req),
        .i_read_complete  (read_complete),
        .i_ui_in          (ui_in),
        .o_uo_out         (uo_out),
        .o_data_out       (data_out),
        .o_data_ready     (data_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the run did not complete", cycle_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // Writes answer in the same cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        req.write_n != periph_pkg::ACC_NONE |-> data_ready)
        else begin
            err_count++;
            $display("write cycle at %0t did not show data ready", $time);
        end

    // Ready comes exactly one cycle after the first read cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(req.read_n != periph_pkg::ACC_NONE) |-> !data_ready ##1 data_ready)
        else begin
            err_count++;
            $display("data ready not one cycle after the read request at %0t", $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n) uo_out == exp_uo)
        else begin
            err_count++;
            $display("mismatch pin_mux expected %02h actual %02h",
                     $sampled(exp_uo), $sampled(uo_out));
        end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int b = 0; b < n; b++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [10:0] user_addr(input logic [3:0] slot, input logic [5:0] off);
        return {1'b0, slot, off};
    endfunction

    function automatic logic [10:0] byte_addr(input logic [3:0] slot, input logic [3:0] off);
        return {1'b1, 2'b00, slot, off};
    endfunction

    function automatic logic [31:0] model_read(input logic [10:0] addr);
        int          slot;
        int          off;
        logic [31:0] v;
        v = '0;
        if (addr[10]) begin
            slot = int'(addr[7:4]);
            off  = int'(addr[3:0]);
            if (slot < `N_BYTE_PERI && off < `BYTE_REGS) begin
                v[7:0] = shadow_byte[slot][off];
            end
        end else if (addr[9:6] == GPIO_USER) begin
            off = int'(addr[5:0]);
            if (off == 0) begin
                v[7:0] = shadow_out;
            end else if (off == 4) begin
                v[7:0] = ui_in;     // Level in the request cycle
            end else if (off >= 32 && off % 4 == 0) begin
                v[FW-1:0] = shadow_sel[(off - 32) / 4];
            end
        end
        return v;
    endfunction

    task automatic refresh_pins();
        int slot;
        for (int p = 0; p < `N_PINS; p++) begin
            slot      = int'(shadow_sel[p][3:0]);
            exp_uo[p] = 1'b0;
            if (shadow_sel[p] == FW'(`GPIO_SLOT)) begin
                exp_uo[p] = shadow_out[p];
            end else if (shadow_sel[p][FW-1] && slot < `N_BYTE_PERI) begin
                exp_uo[p] = shadow_byte[slot][0][p];
            end
        end
    endtask

    task automatic model_write(input logic [10:0] addr, input logic [31:0] wdata);
        int slot;
        int off;
        if (addr[10]) begin
            slot = int'(addr[7:4]);
            off  = int'(addr[3:0]);
            if (slot < `N_BYTE_PERI && off < `BYTE_REGS) begin
                shadow_byte[slot][off] = wdata[7:0];
            end
        end else if (addr[9:6] == GPIO_USER) begin
            off = int'(addr[5:0]);
            if (off == 0) begin
                shadow_out = wdata[7:0];
            end else if (off >= 32 && off % 4 == 0) begin
                shadow_sel[(off - 32) / 4] = wdata[FW-1:0];
            end
        end
        refresh_pins();
    endtask

    task automatic model_reset();
        shadow_out = '0;
        for (int p = 0; p < `N_PINS; p++) begin
            shadow_sel[p] = FW'(`GPIO_SLOT);
        end
        for (int k = 0; k < `N_BYTE_PERI; k++) begin
            for (int r = 0; r < `BYTE_REGS; r++) begin
                shadow_byte[k][r] = '0;
            end
        end
        refresh_pins();
    endtask

    task automatic write_word(input logic [10:0] addr, input logic [31:0] wdata);
        @(negedge clk);
        req.addr    = addr;
        req.wdata   = wdata;
        req.write_n = periph_pkg::ACC_WORD;
        req.read_n  = periph_pkg::ACC_NONE;
        @(negedge clk);
        req.write_n = periph_pkg::ACC_NONE;
        model_write(addr, wdata);   // Register took the value on the last edge
        n_writes++;
    endtask

    task automatic read_word(input string name, input logic [10:0] addr, input int hold_cycles);
        logic [31:0] exp;
        int          waited;
        @(negedge clk);
        req.addr   = addr;
        req.wdata  = rand_bits(32);
        req.read_n = periph_pkg::ACC_WORD;
        exp        = model_read(addr);
        waited     = 0;
        @(negedge clk);
        while (!data_ready && waited < READY_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!data_ready) begin
            err_count++;
            $display("no data ready within %0d cycles for %s", READY_WAIT, name);
        end else begin
            assert (data_out == exp) else begin
                err_count++;
                $display("mismatch %s expected %08h actual %08h", name, exp, data_out);
            end
        end
        // Slot data moves under a held read
        for (int h = 0; h < hold_cycles; h++) begin
            ui_in = 8'(rand_bits(8));
            @(negedge clk);
            assert (data_out == exp) else begin
                err_count++;
                $display("mismatch %s_hold expected %08h actual %08h", name, exp, data_out);
            end
        end
        read_complete = 1'b1;
        req.read_n    = periph_pkg::ACC_NONE;
        @(negedge clk);
        read_complete = 1'b0;
        n_reads++;
    endtask

    task automatic check_pins(input string name);
        assert (uo_out == exp_uo) else begin
            err_count++;
            $display("mismatch %s expected %02h actual %02h", name, exp_uo, uo_out);
        end
    endtask

    initial begin
        logic [3:0] slot_k;
        lfsr          = SEED;
        err_count     = 0;
        cycle_count   = 0;
        n_reads       = 0;
        n_writes      = 0;
        rst_n         = 1'b0;
        req.addr      = '0;
        req.wdata     = '0;
        req.write_n   = periph_pkg::ACC_NONE;
        req.read_n    = periph_pkg::ACC_NONE;
        read_complete = 1'b0;
        ui_in         = '0;
        model_reset();
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        assert (!data_ready && uo_out == '0) else begin
            err_count++;
            $display("outputs not idle after reset, ready %b pins %02h", data_ready, uo_out);
        end

        // GPIO output register and input readback
        write_word(user_addr(GPIO_USER, 6'h00), rand_bits(32));
        check_pins("gpio_out_pins");
        read_word("gpio_out_read", user_addr(GPIO_USER, 6'h00), 0);
        ui_in = 8'(rand_bits(8));
        read_word("gpio_in_read", user_addr(GPIO_USER, 6'h04), 0);
        ui_in = 8'(rand_bits(8));
        read_word("gpio_in_held", user_addr(GPIO_USER, 6'h04), 4);

        // Byte slots, random traffic then a full readback
        for (int n = 0; n < N_RAND; n++) begin
            slot_k = 4'(rand_bits(2));
            write_word(byte_addr(slot_k, 4'(rand_bits(2))), rand_bits(32));
        end
        for (int k = 0; k < `N_BYTE_PERI; k++) begin
            write_word(byte_addr(4'(k), 4'hf), rand_bits(32));   // Dropped
            for (int r = 0; r < `BYTE_REGS; r++) begin
                read_word("byte_readback", byte_addr(4'(k), 4'(r)), 0);
            end
            read_word("byte_upper_offset", byte_addr(4'(k), 4'(4 + rand_bits(3))), 0);
        end
        for (int k = `N_BYTE_PERI; k < `N_SLOTS; k++) begin
            read_word("empty_byte_slot", byte_addr(4'(k), 4'(rand_bits(4))), 0);
        end
        for (int s = 0; s < `N_SLOTS; s++) begin
            if (s != `GPIO_SLOT) begin
                read_word("empty_user_slot", user_addr(4'(s), 6'(rand_bits(6))), 0);
            end
        end

        // Pin function selects
        for (int p = 0; p < `N_PINS; p++) begin
            slot_k = 4'(rand_bits(2));
            write_word(user_addr(GPIO_USER, 6'(32 + 4 * p)), {27'(rand_bits(27)), 1'b1, slot_k});
            write_word(byte_addr(slot_k, 4'h0), rand_bits(32));
            check_pins("pin_from_byte_slot");
            read_word("func_sel_read", user_addr(GPIO_USER, 6'(32 + 4 * p)), 0);
        end
        write_word(user_addr(GPIO_USER, 6'h20), 32'h19);   // Byte slot 9 is empty
        write_word(user_addr(GPIO_USER, 6'h24), 32'h07);   // User slot 7 drives no pins
        check_pins("pin_from_empty_slot");
        write_word(user_addr(GPIO_USER, 6'h28), 32'(`GPIO_SLOT));
        write_word(user_addr(GPIO_USER, 6'h00), rand_bits(32));
        check_pins("pin_back_on_gpio");
        read_word("func_sel_read", user_addr(GPIO_USER, 6'h20), 0);

        repeat (2) @(negedge clk);
        $display("closing report: %0d errors over %0d writes and %0d reads",
                 err_count, n_writes, n_reads);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: hw/addr_decode.sv
/*
 * Peripheral address decoder
 * One-hot slot selects plus the per-slot write strobes
 */

`timescale 1ns/1ps
`include "periph_cfg.svh"

module addr_decode (
    input  periph_pkg::bus_req_t                      i_req,
    output periph_pkg::slot_sel_t                     o_sel,
    output periph_pkg::byte_wr_t [`N_BYTE_PERI-1:0]   o_byte_wr,
    output logic                                      o_gpio_wr
);

    logic       is_write;
    logic [3:0] user_slot;
    logic [3:0] simple_slot;

    assign is_write    = i_req.write_n != periph_pkg::ACC_NONE;
    assign user_slot   = i_req.addr[9:6];
    assign simple_slot = i_req.addr[7:4];

    // Bit 10 splits the two spaces
    always_comb begin
        o_sel = '0;
        if (i_req.addr[10]) begin
            o_sel.simple[simple_slot] = 1'b1;
        end else begin
            o_sel.user[user_slot] = 1'b1;
        end
    end

    // Byte slots see the low nibble and the low data byte
    always_comb begin
        for (int k = 0; k < `N_BYTE_PERI; k++) begin
            o_byte_wr[k].addr = i_req.addr[3:0];
            o_byte_wr[k].data = i_req.wdata[7:0];
            o_byte_wr[k].wr   = is_write && o_sel.simple[k];
        end
    end

    assign o_gpio_wr = is_write && o_sel.user[`GPIO_SLOT];

endmodule

// File: hw/byte_reg_periph.sv
/*
 * Byte-wide register peripheral
 * Four read/write byte registers, register 0 drives the pins
 */

`timescale 1ns/1ps
`include "periph_cfg.svh"

module byte_reg_periph (
    input  logic                  clk,
    input  logic                  rst_n,
    input  periph_pkg::byte_wr_t  i_wr,
    output logic [7:0]            o_rdata,
    output logic [7:0]            o_pins
);

    localparam int IDX_W = $clog2(`BYTE_REGS);

    logic [7:0]       regs [`BYTE_REGS];
    logic             in_range;
    logic [IDX_W-1:0] idx;

    assign in_range = int'(i_wr.addr) < `BYTE_REGS;   // Upper offsets are empty
    assign idx      = i_wr.addr[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < `BYTE_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (i_wr.wr && in_range) begin
            regs[idx] <= i_wr.data;
        end
    end

    assign o_rdata = in_range ? regs[idx] : 8'h00;
    assign o_pins  = regs[0];

    // Pin state moves only on a decoded write to offset 0
    assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) && $changed(regs[0]) |-> $past(i_wr.wr && i_wr.addr == 4'h0))
        else $error("byte register 0 changed without a write strobe");

endmodule

// File: hw/gpio/gpio_ctrl.sv
/*
 * GPIO block
 * Output register, input readback and a function select per pin
 * that routes GPIO or a byte peripheral's pins to each output
 */

`timescale 1ns/1ps
`include "periph_cfg.svh"

module gpio_ctrl (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               i_wr,
    input  logic [5:0]                         i_addr,
    input  logic [31:0]                        i_wdata,
    input  logic [7:0]                         i_ui_in,
    input  logic [`N_BYTE_PERI-1:0][7:0]       i_byte_pins,
    output logic [31:0]                        o_rdata,
    output logic [`N_PINS-1:0]                 o_uo_out
);

    localparam int FW = `FUNC_SEL_W;

    logic [`N_PINS-1:0] gpio_out;
    logic [FW-1:0]      func_sel [`N_PINS];
    logic               sel_hit;
    logic [2:0]         sel_idx;

    // Select words are word aligned from FUNC_SEL_BASE up
    assign sel_hit = (i_addr & 6'b10_0011) == periph_pkg::FUNC_SEL_BASE;
    assign sel_idx = i_addr[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (i_wr && i_addr == periph_pkg::GPIO_OUT) begin
            gpio_out <= i_wdata[`N_PINS-1:0];
        end
    end

    // Every pin starts on the GPIO output register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < `N_PINS; p++) begin
                func_sel[p] <= FW'(`GPIO_SLOT);
            end
        end else if (i_wr && sel_hit) begin
            func_sel[sel_idx] <= i_wdata[FW-1:0];
        end
    end

    // Register readback, zero at unused offsets
    always_comb begin
        o_rdata = '0;
        if (i_addr == periph_pkg::GPIO_OUT) begin
            o_rdata[`N_PINS-1:0] = gpio_out;
        end else if (i_addr == periph_pkg::GPIO_IN) begin
            o_rdata[7:0] = i_ui_in;     // Live input level
        end else if (sel_hit) begin
            o_rdata[FW-1:0] = func_sel[sel_idx];
        end
    end

    // Pin mux
    always_comb begin
        for (int p = 0; p < `N_PINS; p++) begin
            o_uo_out[p] = 1'b0;    // Unpopulated source
            if (func_sel[p] == FW'(`GPIO_SLOT)) begin
                o_uo_out[p] = gpio_out[p];
            end
            for (int k = 0; k < `N_BYTE_PERI; k++) begin
                if (func_sel[p] == FW'((1 << (FW - 1)) | k)) begin
                    o_uo_out[p] = i_byte_pins[k][p];
                end
            end
        end
    end

endmodule

// File: hw/periph_top.sv
/*
 * Peripheral wrapper top level
 * Decoder, GPIO block, byte peripherals and the read return path
 */

`timescale 1ns/1ps
`include "periph_cfg.svh"

module periph_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  periph_pkg::bus_req_t  i_req,
    input  logic                  i_read_complete,
    input  logic [7:0]            i_ui_in,
    output logic [`N_PINS-1:0]    o_uo_out,
    output logic [31:0]           o_data_out,
    output logic                  o_data_ready
);

    periph_pkg::slot_sel_t                    sel;
    periph_pkg::byte_wr_t [`N_BYTE_PERI-1:0]  byte_wr;
    logic                                     gpio_wr;
    logic [31:0]                              gpio_rdata;
    logic [`N_BYTE_PERI-1:0][7:0]             byte_rdata;
    logic [`N_BYTE_PERI-1:0][7:0]             byte_pins;

    addr_decode u_addr_decode (
        .i_req      (i_req),
        .o_sel      (sel),
        .o_byte_wr  (byte_wr),
        .o_gpio_wr  (gpio_wr)
    );

    gpio_ctrl u_gpio_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_wr         (gpio_wr),
        .i_addr       (i_req.addr[5:0]),   // Offset inside the 64 byte slot
        .i_wdata      (i_req.wdata),
        .i_ui_in      (i_ui_in),
        .i_byte_pins  (byte_pins),
        .o_rdata      (gpio_rdata),
        .o_uo_out     (o_uo_out)
    );

    // Byte slots 0 up to N_BYTE_PERI-1
    for (genvar k = 0; k < `N_BYTE_PERI; k++) begin : g_byte_peri
        byte_reg_periph u_byte_reg_periph (
            .clk      (clk),
            .rst_n    (rst_n),
            .i_wr     (byte_wr[k]),
            .o_rdata  (byte_rdata[k]),
            .o_pins   (byte_pins[k])
        );
    end

    read_return u_read_return (
        .clk              (clk),
        .rst_n            (rst_n),
        .i_sel            (sel),
        .i_read_n         (i_req.read_n),
        .i_write_n        (i_req.write_n),
        .i_read_complete  (i_read_complete),
        .i_gpio_rdata     (gpio_rdata),
        .i_byte_rdata     (byte_rdata),
        .o_data_out       (o_data_out),
        .o_data_ready     (o_data_ready)
    );

endmodule

// File: hw/read_return.sv
/*
 * Read return path
 * Muxes the selected slot and holds the registered result
 * until the core signals read complete
 */

`timescale 1ns/1ps
`include "periph_cfg.svh"

module read_return (
    input  logic                           clk,
    input  logic                           rst_n,
    input  periph_pkg::slot_sel_t          i_sel,
    input  periph_pkg::access_e            i_read_n,
    input  periph_pkg::access_e            i_write_n,
    input  logic                           i_read_complete,
    input  logic [31:0]                    i_gpio_rdata,
    input  logic [`N_BYTE_PERI-1:0][7:0]   i_byte_rdata,
    output logic [31:0]                    o_data_out,
    output logic                           o_data_ready
);

    logic [31:0] slot_data;
    logic [31:0] data_r;
    logic        hold;
    logic        ready_r;
    logic        read_req;

    assign read_req = i_read_n != periph_pkg::ACC_NONE;

    // Empty slots read zero
    always_comb begin
        slot_data = '0;
        if (i_sel.user[`GPIO_SLOT]) begin
            slot_data = i_gpio_rdata;
        end
        for (int k = 0; k < `N_BYTE_PERI; k++) begin
            if (i_sel.simple[k]) begin
                slot_data = {24'h0, i_byte_rdata[k]};   // Byte slots zero-extend
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold <= 1'b0;
            end
            if (!hold && read_req) begin
                hold <= 1'b1;
            end
            ready_r <= read_req;   // Every slot answers in one cycle
        end
    end

    // First read cycle captures, later ones keep the held word
    always_ff @(posedge clk) begin
        if (!hold && read_req) begin
            data_r <= slot_data;
        end
    end

    assign o_data_out   = data_r;
    assign o_data_ready = ready_r || i_write_n != periph_pkg::ACC_NONE;

    // Held data survives slot changes until read complete
    assert property (@(posedge clk) disable iff (!rst_n)
        hold |=> $stable(o_data_out))
        else $error("read data moved while the hold flag was set");

endmodule

// File: project.f
+incdir+common
common/periph_pkg.sv
hw/addr_decode.sv
hw/gpio/gpio_ctrl.sv
hw/byte_reg_periph.sv
hw/read_return.sv
hw/periph_top.sv
dv/tb_periph_top.sv
